/* common/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and register file
`define XLEN                32
`define NUM_REGS            32
`define REG_ADDR_W          5

// Instruction queue, depth must be a power of two
`define IQ_DEPTH            8
`define IQ_STALL_THRESHOLD  4

// Cycles from unit valid to write-back
`define ALU_LATENCY         1
`define MUL_LATENCY         3

// Restoring divider steps
`define DIV_CYCLES          32

`endif

/* common/core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

    typedef enum logic [1:0] {
        EXE_NONE,
        EXE_ALU,
        EXE_MUL,
        EXE_DIV
    } exe_unit_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        MD_MUL,
        MD_DIVU,
        MD_REMU
    } md_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_e;

    // One decoded instruction as held in the queue
    typedef struct packed {
        exe_unit_e              unit;
        alu_op_e                alu_op;
        md_op_e                 md_op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       imm;
        logic                   use_imm;
        // Low for rd == x0 and for no-ops
        logic                   reg_write;
    } decoded_instr_t;

endpackage

/* common/exe_if.sv */
`timescale 1ns/10ps

`include "core_defs.svh"

// One issued operation, issue stage to a single execution unit
interface exe_if;
    import core_pkg::*;

    // One-cycle strobe, no back-pressure
    logic                   valid;
    alu_op_e                alu_op;
    md_op_e                 md_op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;

    modport issue (output valid, alu_op, md_op, rd, op_a, op_b);
    modport unit  (input  valid, alu_op, md_op, rd, op_a, op_b);

endinterface

/* source/instr_decoder.sv */
`timescale 1ns/10ps

`include "core_defs.svh"

module instr_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  logic [31:0]             instr_word,
    input  logic                    flush,
    output logic                    dec_valid,
    output core_pkg::decoded_instr_t dec_instr
);
    import core_pkg::*;

    // Major opcodes handled here
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } rv_opcode_e;

    logic [6:0]     funct7;
    logic [2:0]     funct3;
    decoded_instr_t dec;

    assign funct7 = instr_word[31:25];
    assign funct3 = instr_word[14:12];

    always_comb begin
        dec.unit    = EXE_NONE;
        dec.alu_op  = ALU_ADD;
        dec.md_op   = MD_MUL;
        dec.rd      = instr_word[11:7];
        dec.rs1     = instr_word[19:15];
        dec.rs2     = instr_word[24:20];
        dec.imm     = {{(`XLEN-12){instr_word[31]}}, instr_word[31:20]};
        dec.use_imm = 1'b0;

        case (instr_word[6:0])
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    dec.unit = EXE_ALU;
                    case (funct3)
                        3'b000:  dec.alu_op = ALU_ADD;
                        3'b100:  dec.alu_op = ALU_XOR;
                        3'b110:  dec.alu_op = ALU_OR;
                        3'b111:  dec.alu_op = ALU_AND;
                        default: dec.unit = EXE_NONE;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec.unit   = EXE_ALU;
                    dec.alu_op = ALU_SUB;
                end else if (funct7 == 7'b0000001) begin
                    // M extension subset
                    case (funct3)
                        3'b000: dec.unit = EXE_MUL;
                        3'b101: begin
                            dec.unit  = EXE_DIV;
                            dec.md_op = MD_DIVU;
                        end
                        3'b111: begin
                            dec.unit  = EXE_DIV;
                            dec.md_op = MD_REMU;
                        end
                        default: dec.unit = EXE_NONE;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                // rs2 field is immediate bits here, so no register dependency
                dec.rs2     = '0;
                dec.use_imm = 1'b1;
                dec.unit    = EXE_ALU;
                case (funct3)
                    3'b000:  dec.alu_op = ALU_ADD;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec.unit = EXE_NONE;
                endcase
            end
            default: dec.unit = EXE_NONE;
        endcase

        dec.reg_write = (dec.unit != EXE_NONE) && (dec.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (rst)
            dec_valid <= 1'b0;
        else
            dec_valid <= instr_valid && !flush;
    end

    always_ff @(posedge clk) begin
        dec_instr <= dec;
    end

endmodule

/* source/instr_queue.sv */
`timescale 1ns/10ps

`include "core_defs.svh"

module instr_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear,
    input  logic                     push,
    input  core_pkg::decoded_instr_t wr_data,
    input  logic                     pop,
    output core_pkg::decoded_instr_t rd_data,
    output logic                     empty,
    output logic                     almost_full
);
    import core_pkg::*;

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    decoded_instr_t   mem [`IQ_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;
    logic             do_push;
    logic             do_pop;

    // Clear wins over both push and pop
    assign do_push = push && !clear && (count != `IQ_DEPTH);
    assign do_pop  = pop && !clear && !empty;
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (clear)
            count_next = '0;
        else if (do_push && !do_pop)
            count_next = count + 1'b1;
        else if (!do_push && do_pop)
            count_next = count - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Stall level tracks the registered occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            count       <= count_next;
            almost_full <= (count_next >= `IQ_STALL_THRESHOLD);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wr_data;
    end

endmodule

/* issue/instruction_issue.sv */
`timescale 1ns/10ps

`include "core_defs.svh"

module instruction_issue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    // Queue head
    input  logic                     iq_empty,
    input  core_pkg::decoded_instr_t iq_head,
    output logic                     iq_pop,
    // Unit buses
    exe_if.issue                     alu_bus,
    exe_if.issue                     mul_bus,
    exe_if.issue                     div_bus,
    // Write-back
    input  logic                     div_done,
    input  logic                     wb_valid,
    input  logic [`REG_ADDR_W-1:0]   wb_rd,
    input  logic [`XLEN-1:0]         wb_data
);
    import core_pkg::*;

    localparam int MUL_SR_W = `MUL_LATENCY - `ALU_LATENCY;

    logic [`XLEN-1:0]       reg_file [`NUM_REGS];
    logic [`NUM_REGS-1:0]   pending;
    logic [`NUM_REGS-1:0]   pending_next;
    logic [MUL_SR_W-1:0]    mul_inflight;
    logic                   div_pending;
    logic [`REG_ADDR_W-1:0] div_rd;

    logic                   nop_instr;
    logic                   sb_conflict;
    logic                   wb_conflict;
    logic                   fire;
    logic                   issue_alu;
    logic                   issue_mul;
    logic                   issue_div;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       op_b;

    assign nop_instr = (iq_head.unit == EXE_NONE);

    // rd is checked too so write-backs to one register stay in order
    assign sb_conflict = pending[iq_head.rs1] || pending[iq_head.rs2] || pending[iq_head.rd];

    // An ALU firing now would hit the write-back slot of a MUL fired MUL_SR_W cycles ago
    assign wb_conflict = (iq_head.unit == EXE_ALU) && mul_inflight[MUL_SR_W-1];

    // No-ops just drain from the queue
    assign fire = !iq_empty && !flush &&
                  (nop_instr || (!sb_conflict && !wb_conflict && !div_pending));

    assign iq_pop    = fire;
    assign issue_alu = fire && (iq_head.unit == EXE_ALU);
    assign issue_mul = fire && (iq_head.unit == EXE_MUL);
    assign issue_div = fire && (iq_head.unit == EXE_DIV);

    // Operand read, x0 is hardwired
    assign op_a     = (iq_head.rs1 == '0) ? '0 : reg_file[iq_head.rs1];
    assign rs2_data = (iq_head.rs2 == '0) ? '0 : reg_file[iq_head.rs2];
    assign op_b     = iq_head.use_imm ? iq_head.imm : rs2_data;

    always_ff @(posedge clk) begin
        if (wb_valid)
            reg_file[wb_rd] <= wb_data;
    end

    // Scoreboard
    always_comb begin
        pending_next = pending;
        if (wb_valid)
            pending_next[wb_rd] = 1'b0;
        // Aborted divide never writes back
        if (flush && div_pending)
            pending_next[div_rd] = 1'b0;
        if (fire && iq_head.reg_write)
            pending_next[iq_head.rd] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending      <= '0;
            mul_inflight <= '0;
            div_pending  <= 1'b0;
        end else begin
            pending      <= pending_next;
            mul_inflight <= {mul_inflight[MUL_SR_W-2:0], issue_mul};
            if (flush || div_done)
                div_pending <= 1'b0;
            else if (issue_div)
                div_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_div)
            div_rd <= iq_head.rd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_bus.valid <= 1'b0;
            mul_bus.valid <= 1'b0;
            div_bus.valid <= 1'b0;
        end else begin
            alu_bus.valid <= issue_alu;
            mul_bus.valid <= issue_mul;
            div_bus.valid <= issue_div;
        end
    end

    // Operation payload, qualified by the valids above
    always_ff @(posedge clk) begin
        alu_bus.alu_op <= iq_head.alu_op;
        alu_bus.md_op  <= iq_head.md_op;
        alu_bus.rd     <= iq_head.rd;
        alu_bus.op_a   <= op_a;
        alu_bus.op_b   <= op_b;

        mul_bus.alu_op <= iq_head.alu_op;
        mul_bus.md_op  <= iq_head.md_op;
        mul_bus.rd     <= iq_head.rd;
        mul_bus.op_a   <= op_a;
        mul_bus.op_b   <= op_b;

        div_bus.alu_op <= iq_head.alu_op;
        div_bus.md_op  <= iq_head.md_op;
        div_bus.rd     <= iq_head.rd;
        div_bus.op_a   <= op_a;
        div_bus.op_b   <= op_b;
    end

endmodule

/* execute/execute_cluster.sv */
`timescale 1ns/10ps

`include "core_defs.svh"

module execute_cluster (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    exe_if.unit                    alu_bus,
    exe_if.unit                    mul_bus,
    exe_if.unit                    div_bus,
    output logic                   div_done,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);
    import core_pkg::*;

    localparam int CNT_W = $clog2(`DIV_CYCLES);

    logic                   alu_valid;
    logic [`REG_ADDR_W-1:0] alu_rd;
    logic [`XLEN-1:0]       alu_comb;
    logic [`XLEN-1:0]       alu_result;

    logic [2:0]             mul_valid;
    logic [`REG_ADDR_W-1:0] mul_rd [3];
    logic [`XLEN-1:0]       mul_part_lo;
    logic [`XLEN-1:0]       mul_part_hi;
    logic [`XLEN-1:0]       mul_sum;
    logic [`XLEN-1:0]       mul_result;

    div_state_e             div_state;
    logic [CNT_W-1:0]       div_count;
    md_op_e                 div_op;
    logic [`REG_ADDR_W-1:0] div_rd;
    logic [`XLEN-1:0]       div_quot;
    logic [`XLEN-1:0]       div_rem;
    logic [`XLEN-1:0]       div_divisor;
    logic [`XLEN:0]         div_shift;
    logic [`XLEN+1:0]       div_diff;

    // ALU
    always_comb begin
        case (alu_bus.alu_op)
            ALU_SUB: alu_comb = alu_bus.op_a - alu_bus.op_b;
            ALU_AND: alu_comb = alu_bus.op_a & alu_bus.op_b;
            ALU_OR:  alu_comb = alu_bus.op_a | alu_bus.op_b;
            ALU_XOR: alu_comb = alu_bus.op_a ^ alu_bus.op_b;
            default: alu_comb = alu_bus.op_a + alu_bus.op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        alu_rd     <= alu_bus.rd;
        alu_result <= alu_comb;
    end

    // Multiplier: two 32x16 partials, then sum, then output register
    always_ff @(posedge clk) begin
        mul_part_lo <= mul_bus.op_a * mul_bus.op_b[15:0];
        mul_part_hi <= mul_bus.op_a * mul_bus.op_b[31:16];
        mul_sum     <= mul_part_lo + {mul_part_hi[15:0], 16'b0};
        mul_result  <= mul_sum;
        mul_rd[0]   <= mul_bus.rd;
        mul_rd[1]   <= mul_rd[0];
        mul_rd[2]   <= mul_rd[1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
            mul_valid <= '0;
        end else begin
            alu_valid <= alu_bus.valid;
            mul_valid <= {mul_valid[1:0], mul_bus.valid};
        end
    end

    // Restoring divider step
    // A zero divisor naturally yields all ones and the dividend as remainder
    assign div_shift = {div_rem, div_quot[`XLEN-1]};
    assign div_diff  = {1'b0, div_shift} - {2'b00, div_divisor};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            div_state <= DIV_IDLE;
            div_count <= '0;
        end else begin
            case (div_state)
                DIV_IDLE: begin
                    div_count <= '0;
                    if (div_bus.valid)
                        div_state <= DIV_BUSY;
                end
                DIV_BUSY: begin
                    div_count <= div_count + 1'b1;
                    if (div_count == CNT_W'(`DIV_CYCLES - 1))
                        div_state <= DIV_DONE;
                end
                default: div_state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (div_state == DIV_IDLE && div_bus.valid) begin
            div_op      <= div_bus.md_op;
            div_rd      <= div_bus.rd;
            div_quot    <= div_bus.op_a;
            div_divisor <= div_bus.op_b;
            div_rem     <= '0;
        end else if (div_state == DIV_BUSY) begin
            if (!div_diff[`XLEN+1]) begin
                div_rem  <= div_diff[`XLEN-1:0];
                div_quot <= {div_quot[`XLEN-2:0], 1'b1};
            end else begin
                div_rem  <= div_shift[`XLEN-1:0];
                div_quot <= {div_quot[`XLEN-2:0], 1'b0};
            end
        end
    end

    assign div_done = (div_state == DIV_DONE);

    // Write-back merge, issue keeps the sources one-hot
    assign wb_valid = alu_valid || mul_valid[2] || div_done;

    always_comb begin
        if (mul_valid[2]) begin
            wb_rd   = mul_rd[2];
            wb_data = mul_result;
        end else if (div_done) begin
            wb_rd   = div_rd;
            wb_data = (div_op == MD_REMU) ? div_rem : div_quot;
        end else begin
            wb_rd   = alu_rd;
            wb_data = alu_result;
        end
    end

endmodule

/* source/core_issue_top.sv */
`timescale 1ns/10ps

`include "core_defs.svh"

module core_issue_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [31:0]            instr_word,
    input  logic                   flush,
    output logic                   stall,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);
    import core_pkg::*;

    logic           dec_valid;
    decoded_instr_t dec_instr;
    decoded_instr_t iq_head;
    logic           iq_empty;
    logic           iq_pop;
    logic           div_done;

    exe_if alu_bus ();
    exe_if mul_bus ();
    exe_if div_bus ();

    instr_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .flush       (flush),
        .dec_valid   (dec_valid),
        .dec_instr   (dec_instr)
    );

    // Flush stands in for a taken branch and empties the queue
    instr_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .clear       (flush),
        .push        (dec_valid),
        .wr_data     (dec_instr),
        .pop         (iq_pop),
        .rd_data     (iq_head),
        .empty       (iq_empty),
        .almost_full (stall)
    );

    instruction_issue u_issue (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .iq_empty (iq_empty),
        .iq_head  (iq_head),
        .iq_pop   (iq_pop),
        .alu_bus  (alu_bus),
        .mul_bus  (mul_bus),
        .div_bus  (div_bus),
        .div_done (div_done),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    execute_cluster u_execute (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .alu_bus  (alu_bus),
        .mul_bus  (mul_bus),
        .div_bus  (div_bus),
        .div_done (div_done),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

/* testbench/core_issue_tb.sv */
`timescale 1ns/10ps

`include "core_defs.svh"

module core_issue_tb;
    import core_pkg::*;

    localparam int TIMEOUT_PER_INSTR = 60;
    localparam int BURST_LEN         = 48;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;
    localparam logic [6:0] F7_MD      = 7'b0000001;
    localparam logic [2:0] F3_ADD     = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_MUL     = 3'b000;
    localparam logic [2:0] F3_DIVU    = 3'b101;
    localparam logic [2:0] F3_REMU    = 3'b111;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr_word;
    logic        flush;
    logic        stall;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // Architectural state in program order, and the write-backs still owed per register
    logic [31:0] model_regs [`NUM_REGS];
    logic [31:0] exp_q [`NUM_REGS][$];
    logic [31:0] exp_val;
    integer      seed;
    int          value_errors = 0;
    int          other_errors = 0;
    int          sent_count   = 0;
    int          cycle_count  = 0;

    core_issue_top DUT (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .flush       (flush),
        .stall       (stall),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] encode_i(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic bit known_instr(input logic [31:0] w);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = w[31:25];
        f3 = w[14:12];
        if (w[6:0] == OPC_OP_IMM)
            return f3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND};
        if (w[6:0] != OPC_OP)
            return 1'b0;
        if (f7 == F7_BASE)
            return f3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND};
        if (f7 == F7_SUB)
            return f3 == F3_ADD;
        if (f7 == F7_MD)
            return f3 inside {F3_MUL, F3_DIVU, F3_REMU};
        return 1'b0;
    endfunction

    // Expected result of a supported instruction from its source values
    function automatic logic [31:0] reference_result(input logic [31:0] w, input logic [31:0] a,
                                                     input logic [31:0] rs2_val);
        logic [31:0] b;
        b = (w[6:0] == OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : rs2_val;
        if (w[6:0] == OPC_OP && w[31:25] == F7_SUB)
            return a - b;
        if (w[6:0] == OPC_OP && w[31:25] == F7_MD) begin
            case (w[14:12])
                F3_MUL:  return a * b;
                F3_DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
                default: return (b == 0) ? a : a % b;
            endcase
        end
        case (w[14:12])
            F3_XOR:  return a ^ b;
            F3_OR:   return a | b;
            F3_AND:  return a & b;
            default: return a + b;
        endcase
    endfunction

    task automatic model_update(input logic [31:0] w);
        logic [4:0]  rd;
        logic [31:0] res;
        rd = w[11:7];
        // x0 results are discarded, unknown encodings are skipped
        if (known_instr(w) && rd != 5'd0) begin
            res = reference_result(w, model_regs[w[19:15]], model_regs[w[24:20]]);
            model_regs[rd] = res;
            exp_q[rd].push_back(res);
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_word(input logic [31:0] w, input bit modeled);
        while (stall)
            @(negedge clk);
        instr_valid = 1'b1;
        instr_word  = w;
        if (modeled)
            model_update(w);
        sent_count++;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic random_word(output logic [31:0] w);
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        kind = $unsigned($random(seed)) % 14;
        rd   = $random(seed);
        rs1  = $random(seed);
        rs2  = $random(seed);
        imm  = $random(seed);
        case (kind)
            0:       w = encode_r(F7_BASE, F3_ADD, rd, rs1, rs2);
            1:       w = encode_r(F7_SUB, F3_ADD, rd, rs1, rs2);
            2:       w = encode_r(F7_BASE, F3_AND, rd, rs1, rs2);
            3:       w = encode_r(F7_BASE, F3_OR, rd, rs1, rs2);
            4:       w = encode_r(F7_BASE, F3_XOR, rd, rs1, rs2);
            5:       w = encode_i(F3_ADD, rd, rs1, imm);
            6:       w = encode_i(F3_AND, rd, rs1, imm);
            7:       w = encode_i(F3_OR, rd, rs1, imm);
            8:       w = encode_i(F3_XOR, rd, rs1, imm);
            9:       w = encode_r(F7_MD, F3_MUL, rd, rs1, rs2);
            10:      w = encode_r(F7_MD, F3_DIVU, rd, rs1, rs2);
            11:      w = encode_r(F7_MD, F3_REMU, rd, rs1, rs2);
            // MULH, not supported
            12:      w = encode_r(F7_MD, 3'b001, rd, rs1, rs2);
            default: w = {imm, rs1, 3'b010, rd, OPC_LOAD};
        endcase
    endtask

    function automatic bit queues_empty();
        for (int r = 0; r < `NUM_REGS; r++) begin
            if (exp_q[r].size() != 0)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic wait_drain();
        while (!queues_empty())
            @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %s: got %08h, expected %08h", name, actual, expected);
        end
    endtask

    task automatic alu_chain();
        send_word(encode_i(F3_ADD, 5'd1, 5'd0, 12'd5), 1'b1);
        send_word(encode_i(F3_ADD, 5'd2, 5'd1, 12'hffd), 1'b1);
        send_word(encode_r(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2), 1'b1);
        send_word(encode_r(F7_SUB, F3_ADD, 5'd4, 5'd2, 5'd3), 1'b1);
        send_word(encode_r(F7_BASE, F3_XOR, 5'd5, 5'd4, 5'd3), 1'b1);
        send_word(encode_r(F7_BASE, F3_AND, 5'd6, 5'd5, 5'd4), 1'b1);
        send_word(encode_r(F7_BASE, F3_OR, 5'd7, 5'd6, 5'd1), 1'b1);
        send_word(encode_i(F3_XOR, 5'd8, 5'd7, 12'h7ff), 1'b1);
        send_word(encode_i(F3_AND, 5'd9, 5'd8, 12'h0f0), 1'b1);
        send_word(encode_i(F3_OR, 5'd10, 5'd9, 12'h800), 1'b1);
        // Writes to x0 must not be visible to later reads
        send_word(encode_i(F3_ADD, 5'd0, 5'd10, 12'd12), 1'b1);
        send_word(encode_r(F7_BASE, F3_ADD, 5'd11, 5'd0, 5'd10), 1'b1);
        repeat (6)
            send_word(encode_r(F7_BASE, F3_ADD, 5'd1, 5'd1, 5'd1), 1'b1);
    endtask

    task automatic mul_alu_mix();
        send_word(encode_r(F7_MD, F3_MUL, 5'd12, 5'd10, 5'd8), 1'b1);
        send_word(encode_i(F3_ADD, 5'd13, 5'd0, 12'd7), 1'b1);
        send_word(encode_r(F7_BASE, F3_ADD, 5'd14, 5'd1, 5'd2), 1'b1);
        send_word(encode_r(F7_MD, F3_MUL, 5'd15, 5'd12, 5'd13), 1'b1);
        send_word(encode_r(F7_BASE, F3_XOR, 5'd16, 5'd15, 5'd14), 1'b1);
        // Same rd twice, order must hold
        send_word(encode_r(F7_MD, F3_MUL, 5'd12, 5'd4, 5'd4), 1'b1);
        send_word(encode_i(F3_ADD, 5'd12, 5'd12, 12'd1), 1'b1);
        for (int i = 0; i < 4; i++) begin
            send_word(encode_r(F7_MD, F3_MUL, 5'(17 + i), 5'(1 + i), 5'(4 + i)), 1'b1);
            send_word(encode_i(F3_ADD, 5'(21 + i), 5'(2 + i), 12'(i)), 1'b1);
        end
    endtask

    task automatic divide_cases();
        send_word(encode_r(F7_MD, F3_DIVU, 5'd25, 5'd10, 5'd13), 1'b1);
        send_word(encode_r(F7_MD, F3_REMU, 5'd26, 5'd10, 5'd13), 1'b1);
        // Divide by zero
        send_word(encode_r(F7_MD, F3_DIVU, 5'd27, 5'd4, 5'd0), 1'b1);
        send_word(encode_r(F7_MD, F3_REMU, 5'd28, 5'd4, 5'd0), 1'b1);
        send_word(encode_r(F7_MD, F3_DIVU, 5'd29, 5'd3, 5'd1), 1'b1);
        send_word(encode_r(F7_BASE, F3_ADD, 5'd30, 5'd25, 5'd26), 1'b1);
        send_word(encode_r(F7_MD, F3_MUL, 5'd31, 5'd30, 5'd27), 1'b1);
    endtask

    task automatic unknown_mix();
        send_word(encode_i(F3_ADD, 5'd5, 5'd0, 12'd100), 1'b1);
        send_word(encode_r(F7_MD, 3'b001, 5'd5, 5'd1, 5'd2), 1'b1);
        send_word(encode_i(F3_ADD, 5'd6, 5'd5, 12'd1), 1'b1);
        send_word({12'd4, 5'd5, 3'b010, 5'd6, OPC_LOAD}, 1'b1);
        send_word(encode_r(F7_SUB, 3'b101, 5'd7, 5'd6, 5'd1), 1'b1);
        send_word(encode_r(F7_BASE, F3_ADD, 5'd7, 5'd5, 5'd6), 1'b1);
        send_word(encode_i(3'b001, 5'd7, 5'd7, 12'd3), 1'b1);
        send_word(encode_r(F7_BASE, F3_OR, 5'd8, 5'd7, 5'd5), 1'b1);
    endtask

    task automatic divide_then_flush();
        wait_drain();
        // All of these sit behind the divide and are thrown away by the flush
        send_word(encode_r(F7_MD, F3_REMU, 5'd20, 5'd10, 5'd13), 1'b0);
        send_word(encode_r(F7_BASE, F3_ADD, 5'd21, 5'd20, 5'd1), 1'b0);
        send_word(encode_r(F7_MD, F3_MUL, 5'd22, 5'd20, 5'd20), 1'b0);
        send_word(encode_i(F3_ADD, 5'd23, 5'd2, 12'd3), 1'b0);
        send_word(encode_i(F3_ADD, 5'd24, 5'd3, 12'd9), 1'b0);
        repeat (3) @(negedge clk);
        // Four words wait behind the divide
        check_value("stall", stall, 32'd1);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_value("stall", stall, 32'd0);
        send_word(encode_r(F7_BASE, F3_ADD, 5'd21, 5'd20, 5'd1), 1'b1);
        send_word(encode_r(F7_MD, F3_DIVU, 5'd20, 5'd10, 5'd13), 1'b1);
        send_word(encode_r(F7_BASE, F3_ADD, 5'd22, 5'd20, 5'd21), 1'b1);
        send_word(encode_r(F7_MD, F3_MUL, 5'd23, 5'd22, 5'd2), 1'b1);
    endtask

    // Write-back checker
    always @(negedge clk) begin
        // x0 write-backs carry no architectural state
        if (!rst && wb_valid && wb_rd != 5'd0) begin
            if (exp_q[wb_rd].size() == 0) begin
                other_errors++;
                $display("Unexpected write-back to x%0d with value %08h", wb_rd, wb_data);
            end else begin
                exp_val = exp_q[wb_rd].pop_front();
                check_value($sformatf("wb_data x%0d", wb_rd), wb_data, exp_val);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_PER_INSTR * (sent_count + 4)) begin
            $display("Timeout after %0d cycles with %0d instructions sent",
                     cycle_count, sent_count);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] w;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr_word  = '0;
        flush       = 1'b0;
        seed        = 32'hf2c8;
        for (int r = 0; r < `NUM_REGS; r++)
            model_regs[r] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Idle outputs straight out of reset
        check_value("stall", stall, 32'd0);
        check_value("wb_valid", wb_valid, 32'd0);

        alu_chain();
        mul_alu_mix();
        divide_cases();
        unknown_mix();
        wait_drain();

        // Random burst at full rate, held back only by stall
        for (int i = 0; i < BURST_LEN; i++) begin
            random_word(w);
            send_word(w, 1'b1);
        end
        wait_drain();

        divide_then_flush();
        wait_drain();
        repeat (10) @(negedge clk);

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+common
common/core_pkg.sv
common/exe_if.sv
source/instr_decoder.sv
source/instr_queue.sv
issue/instruction_issue.sv
execute/execute_cluster.sv
source/core_issue_top.sv
testbench/core_issue_tb.sv
